/* filelist.f */
design/emesh_pkg.sv
design/erx_cfg_pkg.sv
design/erx_chan.sv
design/erx_arbiter.sv
design/erx_cfg.sv
design/erx_remap.sv
design/erx_top.sv
tb/erx_assertions.sv
tb/erx_tb.sv

/* tb/erx_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module erx_tb
   import emesh_pkg::*;
   import erx_cfg_pkg::*;
();

   localparam logic [11:0] LINK_ID = 12'h808;

   // cycles allowed per test, reset included
   localparam int BUDGET_RESET = 100;
   localparam int BUDGET_STATIC = 150;
   localparam int BUDGET_DYNAMIC = 150;
   localparam int BUDGET_ARB = 100;
   localparam int BUDGET_BACKPRESSURE = 100;
   localparam int CYCLE_LIMIT = 2 * (BUDGET_RESET + BUDGET_STATIC + BUDGET_DYNAMIC
                                     + BUDGET_ARB + BUDGET_BACKPRESSURE);

   logic          clk;
   logic          reset;
   logic          wr_access;
   emesh_packet_t wr_packet;
   logic          wr_wait;
   logic          rd_access;
   emesh_packet_t rd_packet;
   logic          rd_wait;
   logic          cfg_write;
   cfg_reg_t      cfg_reg;
   logic [31:0]   cfg_data;
   logic          out_access;
   emesh_packet_t out_packet;
   logic          out_wait;

   // shadow of the configuration registers
   remap_mode_t   cur_mode;
   logic [11:0]   cur_sel;
   logic [11:0]   cur_pat;
   logic [31:0]   cur_base;

   logic [31:0]   lcg_state = 32'd70912;
   int            cycle_count;
   int            error_count = 0;
   emesh_packet_t exp_wr[$];
   emesh_packet_t exp_rd[$];
   emesh_packet_t got_all[$];   // output packets in arrival order

   erx_top #(.LINK_ID(LINK_ID)) DUT (.*);

   initial
   begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   function automatic logic [31:0] lcg_next();
      lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
      return lcg_state;
   endfunction

   // log2 of the column id
   function automatic int col_shift();
      int s;
      s = 0;
      while ((6'd1 << s) < LINK_ID[5:0])
         s++;
      return s;
   endfunction

   function automatic emesh_packet_t make_packet(input emesh_op_t op, input logic [31:0] dst);
      emesh_packet_t p;
      logic [31:0]   r;
      r = lcg_next();
      p.srcaddr = lcg_next();
      p.data = lcg_next();
      p.dstaddr = dst;
      p.ctrlmode = r[7:4];
      p.reserved = 1'b0;
      p.datamode = r[1:0];
      p.op = op;
      return p;
   endfunction

   // expected packet on the output side
   function automatic emesh_packet_t remap_model(input emesh_packet_t p);
      emesh_packet_t r;
      logic [31:0]   a;
      int            i;
      r = p;
      a = p.dstaddr;
      if (p.op == OP_READ || a[31:20] == LINK_ID)
         return r;   // reads and own-link traffic
      if (cur_mode == REMAP_STATIC)
      begin
         for (i = 0; i < 12; i++)
         begin
            if (cur_sel[i])
               r.dstaddr[20 + i] = cur_pat[i];   // mask bit set takes the pattern
         end
      end
      else if (cur_mode == REMAP_DYNAMIC)
      begin
         r.dstaddr = a + cur_base - LINK_ID[5:0] * 32'h0010_0000
                     - a[31:26] * (32'd1 << col_shift());
      end
      return r;
   endfunction

   task automatic abort_run(input string line);
      error_count++;
      $display("%s", line);
      $display("tests failed");
      $fatal(1, "run stopped at the first failure");
   endtask

   task automatic compare_packet(input emesh_packet_t got, input emesh_packet_t exp,
                                 input string what);
      if (got !== exp)
         abort_run($sformatf("ERROR at %0t ns: %s got %h expected %h", $time, what, got, exp));
   endtask

   task automatic compare_bit(input logic got, input logic exp, input string what);
      if (got !== exp)
         abort_run($sformatf("ERROR at %0t ns: %s got %b expected %b", $time, what, got, exp));
   endtask

   task automatic do_reset();
      reset = 1'b1;
      repeat (5) @(posedge clk);
      #2 reset = 1'b0;
      cur_mode = REMAP_NONE;
      cur_sel = 12'd0;
      cur_pat = 12'd0;
      cur_base = 32'd0;
   endtask

   task automatic write_cfg(input cfg_reg_t r, input logic [31:0] d);
      cfg_write = 1'b1;
      cfg_reg = r;
      cfg_data = d;
      @(posedge clk);
      #2 cfg_write = 1'b0;
      case (r)
         REG_MODE:    cur_mode = remap_mode_t'(d[1:0]);
         REG_SEL:     cur_sel = d[11:0];
         REG_PATTERN: cur_pat = d[11:0];
         default:     cur_base = d;
      endcase
   endtask

   // holds the packet until the channel takes it
   task automatic send_packet(input logic to_rd, input emesh_packet_t p);
      if (to_rd)
      begin
         rd_access = 1'b1;
         rd_packet = p;
         exp_rd.push_back(remap_model(p));
      end
      else
      begin
         wr_access = 1'b1;
         wr_packet = p;
         exp_wr.push_back(remap_model(p));
      end
      do @(negedge clk); while (to_rd ? rd_wait : wr_wait);
      @(posedge clk);
      #2;
      if (to_rd)
         rd_access = 1'b0;
      else
         wr_access = 1'b0;
   endtask

   task automatic check_outputs(input logic alternate);
      int iw;
      int ir;
      int total;
      total = exp_wr.size() + exp_rd.size();
      while (got_all.size() < total)
         @(posedge clk);
      repeat (4) @(posedge clk);   // room for a duplicate to show up
      #2;
      if (got_all.size() != total)
         abort_run($sformatf("%0d packets came out, %0d were sent", got_all.size(), total));
      iw = 0;
      ir = 0;
      foreach (got_all[i])
      begin
         if (alternate)
            compare_bit(got_all[i].op == OP_WRITE, (i % 2) == 0, "round-robin order");
         if (got_all[i].op == OP_READ)
         begin
            compare_packet(got_all[i], exp_rd[ir], "read channel packet");
            ir++;
         end
         else
         begin
            compare_packet(got_all[i], exp_wr[iw], "write channel packet");
            iw++;
         end
      end
      exp_wr.delete();
      exp_rd.delete();
      got_all.delete();
   endtask

   task automatic test_reset();
      @(negedge clk);
      compare_bit(out_access, 1'b0, "out_access after reset");
      compare_bit(wr_wait, 1'b0, "wr_wait after reset");
      compare_bit(rd_wait, 1'b0, "rd_wait after reset");
      @(posedge clk);
      #2 send_packet(1'b0, make_packet(OP_WRITE, lcg_next()));
      @(negedge clk);
      compare_bit(out_access, 1'b0, "out_access one edge after accept");
      @(negedge clk);
      compare_bit(out_access, 1'b1, "out_access two edges after send");
      compare_packet(out_packet, exp_wr[0], "first packet");
      check_outputs(1'b0);
   endtask

   task automatic test_static();
      emesh_packet_t p;
      write_cfg(REG_SEL, 32'h0000_0F0F);
      write_cfg(REG_PATTERN, 32'h0000_0A5C);
      write_cfg(REG_MODE, {30'd0, REMAP_STATIC});
      repeat (4) send_packet(1'b0, make_packet(OP_WRITE, lcg_next()));
      send_packet(1'b1, make_packet(OP_READ, lcg_next()));   // bypass by opcode
      p = make_packet(OP_WRITE, lcg_next());
      p.dstaddr[31:20] = LINK_ID;   // own link keeps its address
      send_packet(1'b0, p);
      check_outputs(1'b0);
   endtask

   task automatic test_dynamic();
      write_cfg(REG_BASE, lcg_next());
      write_cfg(REG_MODE, {30'd0, REMAP_DYNAMIC});
      repeat (5) send_packet(1'b0, make_packet(OP_WRITE, lcg_next()));
      check_outputs(1'b0);
   endtask

   task automatic test_arbitration();
      emesh_packet_t w0;
      emesh_packet_t w1;
      emesh_packet_t r0;
      emesh_packet_t r1;
      do_reset();   // write priority again
      w0 = make_packet(OP_WRITE, lcg_next());
      w1 = make_packet(OP_WRITE, lcg_next());
      r0 = make_packet(OP_READ, lcg_next());
      r1 = make_packet(OP_READ, lcg_next());
      fork
         begin
            send_packet(1'b0, w0);
            send_packet(1'b0, w1);
         end
         begin
            send_packet(1'b1, r0);
            send_packet(1'b1, r1);
         end
      join
      check_outputs(1'b1);
   endtask

   task automatic test_backpressure();
      out_wait = 1'b1;
      fork
         repeat (4) send_packet(1'b0, make_packet(OP_WRITE, lcg_next()));
         repeat (4) send_packet(1'b1, make_packet(OP_READ, lcg_next()));
         begin
            do @(negedge clk); while (!(wr_wait && rd_wait));
            repeat (3) @(posedge clk);
            #2;
            // buffered packets must not reach the output yet
            compare_bit(out_access, 1'b0, "out_access while stalled");
            out_wait = 1'b0;
         end
      join
      check_outputs(1'b0);
   endtask

   // one output transfer per cycle with access high and wait low
   initial
   begin
      forever
      begin
         @(negedge clk);
         if (!reset && out_access && !out_wait)
            got_all.push_back(out_packet);
      end
   end

   initial
   begin
      cycle_count = 0;
      while (cycle_count < CYCLE_LIMIT)
      begin
         @(posedge clk);
         cycle_count++;
      end
      abort_run($sformatf("the run did not finish within %0d clock cycles", CYCLE_LIMIT));
   end

   initial
   begin
      reset = 1'b1;
      wr_access = 1'b0;
      wr_packet = '0;
      rd_access = 1'b0;
      rd_packet = '0;
      cfg_write = 1'b0;
      cfg_reg = REG_MODE;
      cfg_data = 32'd0;
      out_wait = 1'b0;
      do_reset();
      test_reset();
      test_static();
      test_dynamic();
      test_arbitration();
      test_backpressure();
      if (error_count == 0)
         $display("all tests passed");
      else
         $display("tests failed");
      $finish;
   end

endmodule

`default_nettype wire

/* tb/erx_assertions.sv */
`timescale 1ns/1ns
`default_nettype none

module erx_assertions
   import emesh_pkg::*;
(
   input wire logic                clk,
   input wire logic                reset,
   input wire logic                out_access,
   input wire logic [PACKET_W-1:0] out_packet,
   input wire logic                out_wait,
   input wire logic                wr_access,
   input wire logic                wr_wait,
   input wire logic                wr_req_access,
   input wire emesh_packet_t       wr_req_packet
);

   // output register frozen during a stall
   a_out_stable: assert property (@(posedge clk) disable iff (reset)
      out_wait |=> $stable(out_access) && $stable(out_packet))
      else $error("out_access or out_packet changed while out_wait was high");

   a_reset_idle: assert property (@(posedge clk) reset |-> !out_access)
      else $error("out_access high during reset");

   // stalled write stays in the buffer, so it is taken only once
   a_wr_held: assert property (@(posedge clk) disable iff (reset)
      wr_access && wr_wait |=> wr_req_access && $stable(wr_req_packet))
      else $error("write buffer changed while wr_wait held the packet");

endmodule

bind erx_top erx_assertions u_assertions (
   .clk           (clk),
   .reset         (reset),
   .out_access    (out_access),
   .out_packet    (out_packet),
   .out_wait      (out_wait),
   .wr_access     (wr_access),
   .wr_wait       (wr_wait),
   .wr_req_access (wr_req_access),
   .wr_req_packet (wr_req_packet)
);

`default_nettype wire

/* design/erx_top.sv */
`timescale 1ns/1ns
`default_nettype none

module erx_top
   import emesh_pkg::*;
   import erx_cfg_pkg::*;
#(
   parameter logic [11:0] LINK_ID = 12'h808
)
(
   input  wire logic                clk,
   input  wire logic                reset,

   // write transactions
   input  wire logic                wr_access,
   input  wire logic [PACKET_W-1:0] wr_packet,
   output logic                     wr_wait,

   // read requests
   input  wire logic                rd_access,
   input  wire logic [PACKET_W-1:0] rd_packet,
   output logic                     rd_wait,

   // configuration writes
   input  wire logic                cfg_write,
   input  wire cfg_reg_t            cfg_reg,
   input  wire logic [31:0]         cfg_data,

   // remapped output
   output logic                     out_access,
   output logic [PACKET_W-1:0]      out_packet,
   input  wire logic                out_wait
);

   // channel requests
   logic          wr_req_access;
   emesh_packet_t wr_req_packet;
   logic          wr_req_wait;
   logic          rd_req_access;
   emesh_packet_t rd_req_packet;
   logic          rd_req_wait;

   // arbiter to remap
   logic          arb_access;
   emesh_packet_t arb_packet;
   logic          arb_wait;

   remap_mode_t   remap_mode;
   logic [11:0]   remap_sel;
   logic [11:0]   remap_pattern;
   logic [31:0]   remap_base;

   erx_chan u_wr_chan (
      .clk        (clk),
      .reset      (reset),
      .in_access  (wr_access),
      .in_packet  (wr_packet),
      .in_wait    (wr_wait),
      .req_access (wr_req_access),
      .req_packet (wr_req_packet),
      .req_wait   (wr_req_wait)
   );

   erx_chan u_rd_chan (
      .clk        (clk),
      .reset      (reset),
      .in_access  (rd_access),
      .in_packet  (rd_packet),
      .in_wait    (rd_wait),
      .req_access (rd_req_access),
      .req_packet (rd_req_packet),
      .req_wait   (rd_req_wait)
   );

   erx_arbiter u_arbiter (
      .clk        (clk),
      .reset      (reset),
      .wr_access  (wr_req_access),
      .wr_packet  (wr_req_packet),
      .wr_wait    (wr_req_wait),
      .rd_access  (rd_req_access),
      .rd_packet  (rd_req_packet),
      .rd_wait    (rd_req_wait),
      .arb_access (arb_access),
      .arb_packet (arb_packet),
      .arb_wait   (arb_wait)
   );

   erx_cfg u_cfg (
      .clk           (clk),
      .reset         (reset),
      .cfg_write     (cfg_write),
      .cfg_reg       (cfg_reg),
      .cfg_data      (cfg_data),
      .remap_mode    (remap_mode),
      .remap_sel     (remap_sel),
      .remap_pattern (remap_pattern),
      .remap_base    (remap_base)
   );

   erx_remap #(
      .LINK_ID (LINK_ID)
   ) u_remap (
      .clk           (clk),
      .reset         (reset),
      .in_access     (arb_access),
      .in_packet     (arb_packet),
      .in_wait       (arb_wait),
      .remap_mode    (remap_mode),
      .remap_sel     (remap_sel),
      .remap_pattern (remap_pattern),
      .remap_base    (remap_base),
      .out_access    (out_access),
      .out_packet    (out_packet),
      .out_wait      (out_wait)
   );

endmodule

`default_nettype wire

/* design/erx_remap.sv */
`timescale 1ns/1ns
`default_nettype none

module erx_remap
   import emesh_pkg::*;
   import erx_cfg_pkg::*;
#(
   parameter logic [11:0] LINK_ID = 12'h808
)
(
   input  wire logic          clk,
   input  wire logic          reset,

   // from arbiter
   input  wire logic          in_access,
   input  wire emesh_packet_t in_packet,
   output logic               in_wait,

   // configuration
   input  wire remap_mode_t   remap_mode,
   input  wire logic [11:0]   remap_sel,
   input  wire logic [11:0]   remap_pattern,
   input  wire logic [31:0]   remap_base,

   // toward transmit side
   output logic               out_access,
   output emesh_packet_t      out_packet,
   input  wire logic          out_wait
);

   // column id, assumed a power of two
   localparam logic [5:0] COL_ID    = LINK_ID[5:0];
   localparam int         COL_SHIFT = $clog2(COL_ID);

   logic [31:0]   addr_in;
   logic [31:0]   static_addr;
   logic [31:0]   dynamic_addr;
   logic [31:0]   addr_out;
   logic          bypass;
   emesh_packet_t next_packet;

   assign addr_in = in_packet.dstaddr;

   assign static_addr[31:20] = (remap_sel & remap_pattern) | (~remap_sel & addr_in[31:20]);
   assign static_addr[19:0]  = addr_in[19:0];

   // compressed map: drop own column offset, add base, squeeze upper rows
   assign dynamic_addr = addr_in
                       - ({26'd0, COL_ID} << 20)
                       + remap_base
                       - ({26'd0, addr_in[31:26]} << COL_SHIFT);

   // reads and traffic for this link keep their address
   assign bypass = (remap_mode == REMAP_NONE) | (in_packet.op == OP_READ) |
                   (addr_in[31:20] == LINK_ID);

   always_comb
   begin
      next_packet = in_packet;
      if (bypass)
         addr_out = addr_in;
      else if (remap_mode == REMAP_STATIC)
         addr_out = static_addr;
      else
         addr_out = dynamic_addr;
      next_packet.dstaddr = addr_out;
   end

   assign in_wait = out_wait;  // stall passes straight back

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
         out_access <= 1'b0;
      else if (~out_wait)
         out_access <= in_access;
   end

   always_ff @(posedge clk)
   begin
      if (~out_wait)
         out_packet <= next_packet;
   end

endmodule

`default_nettype wire

/* design/erx_cfg.sv */
`timescale 1ns/1ns
`default_nettype none

module erx_cfg
   import erx_cfg_pkg::*;
(
   input  wire logic        clk,
   input  wire logic        reset,

   // write port
   input  wire logic        cfg_write,
   input  wire cfg_reg_t    cfg_reg,
   input  wire logic [31:0] cfg_data,

   // remap settings
   output remap_mode_t      remap_mode,
   output logic [11:0]      remap_sel,
   output logic [11:0]      remap_pattern,
   output logic [31:0]      remap_base
);

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         remap_mode    <= REMAP_NONE;
         remap_sel     <= 12'd0;
         remap_pattern <= 12'd0;
         remap_base    <= 32'd0;
      end
      else if (cfg_write)
      begin
         case (cfg_reg)
            REG_MODE:
            begin
               remap_mode <= remap_mode_t'(cfg_data[1:0]);
            end
            REG_SEL:
            begin
               remap_sel <= cfg_data[11:0];  // 1 = take pattern bit
            end
            REG_PATTERN:
            begin
               remap_pattern <= cfg_data[11:0];
            end
            default:
            begin
               remap_base <= cfg_data;  // REG_BASE
            end
         endcase
      end
   end

endmodule

`default_nettype wire

/* design/erx_arbiter.sv */
`timescale 1ns/1ns
`default_nettype none

module erx_arbiter
   import emesh_pkg::*;
(
   input  wire logic          clk,
   input  wire logic          reset,

   // write channel request
   input  wire logic          wr_access,
   input  wire emesh_packet_t wr_packet,
   output logic               wr_wait,

   // read channel request
   input  wire logic          rd_access,
   input  wire emesh_packet_t rd_packet,
   output logic               rd_wait,

   // toward the remap stage
   output logic               arb_access,
   output emesh_packet_t      arb_packet,
   input  wire logic          arb_wait
);

   // which channel won the last completed transfer
   typedef enum logic
   {
      LAST_WR = 1'b0,
      LAST_RD = 1'b1
   } last_grant_t;

   last_grant_t last_grant;
   logic        grant_wr;
   logic        grant_rd;
   logic        xfer;

   // write wins when alone, or when read went last
   assign grant_wr = wr_access & (~rd_access | (last_grant == LAST_RD));
   assign grant_rd = rd_access & ~grant_wr;

   assign arb_access = wr_access | rd_access;
   assign arb_packet = grant_rd ? rd_packet : wr_packet;

   // losers and stalled winners both hold
   assign wr_wait = wr_access & (~grant_wr | arb_wait);
   assign rd_wait = rd_access & (~grant_rd | arb_wait);

   assign xfer = arb_access & ~arb_wait;

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         last_grant <= LAST_RD;  // gives write priority out of reset
      end
      else if (xfer)
      begin
         last_grant <= grant_rd ? LAST_RD : LAST_WR;
      end
   end

endmodule

`default_nettype wire

/* design/erx_chan.sv */
`timescale 1ns/1ns
`default_nettype none

module erx_chan
   import emesh_pkg::*;
(
   input  wire logic          clk,
   input  wire logic          reset,

   // upstream side
   input  wire logic          in_access,
   input  wire emesh_packet_t in_packet,
   output logic               in_wait,

   // request toward arbiter
   output logic               req_access,
   output emesh_packet_t      req_packet,
   input  wire logic          req_wait
);

   logic          full;
   emesh_packet_t buf_packet;
   logic          fill;   // input transfer this cycle
   logic          drain;  // buffered packet leaves this cycle

   assign drain = full & ~req_wait;

   // only stall upstream when the slot stays occupied
   assign in_wait = full & req_wait;
   assign fill    = in_access & ~in_wait;

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         full <= 1'b0;
      end
      else if (fill)
      begin
         full <= 1'b1;  // refill on the same edge as a drain
      end
      else if (drain)
      begin
         full <= 1'b0;
      end
   end

   always_ff @(posedge clk)
   begin
      if (fill)
      begin
         buf_packet <= in_packet;
      end
   end

   assign req_access = full;
   assign req_packet = buf_packet;

endmodule

`default_nettype wire

/* design/erx_cfg_pkg.sv */
`default_nettype none

package erx_cfg_pkg;

   // how the destination address gets rewritten
   typedef enum logic [1:0]
   {
      REMAP_NONE    = 2'b00,
      REMAP_STATIC  = 2'b01,  // upper 12 bits from pattern/mask
      REMAP_DYNAMIC = 2'b10   // continuity map with programmable base
   } remap_mode_t;

   // register select for configuration writes
   typedef enum logic [1:0]
   {
      REG_MODE    = 2'b00,
      REG_SEL     = 2'b01,
      REG_PATTERN = 2'b10,
      REG_BASE    = 2'b11
   } cfg_reg_t;

endpackage

`default_nettype wire

/* design/emesh_pkg.sv */
`default_nettype none

package emesh_pkg;

   // field widths of a mesh packet
   localparam int ADDR_W = 32;
   localparam int DATA_W = 32;
   localparam int CTRLMODE_W = 4;
   localparam int DATAMODE_W = 2;

   // srcaddr + data + dstaddr + 8 control bits
   localparam int PACKET_W = 2 * ADDR_W + DATA_W + CTRLMODE_W + DATAMODE_W + 2;

   // opcode sits in bit 0 of the packet
   typedef enum logic
   {
      OP_READ  = 1'b0,
      OP_WRITE = 1'b1
   } emesh_op_t;

   // first field is the msb end, op lands in bit 0
   typedef struct packed
   {
      logic [ADDR_W-1:0]     srcaddr;   // [103:72]
      logic [DATA_W-1:0]     data;      // [71:40]
      logic [ADDR_W-1:0]     dstaddr;   // [39:8]
      logic [CTRLMODE_W-1:0] ctrlmode;  // [7:4]
      logic                  reserved;  // [3]
      logic [DATAMODE_W-1:0] datamode;  // [2:1]
      emesh_op_t             op;        // [0]
   } emesh_packet_t;

endpackage

`default_nettype wire
